// ==== cpu_pkg.sv ====
/* core shared types */

package cpu_pkg;

  localparam int xlen = 32;

  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;

  // major opcodes
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;

  typedef struct packed {
    logic [6:0] funct7;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    reg_addr_t  rd;
    logic [6:0] opcode;
  } inst_r_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_addr_t   rs1;
    logic [2:0]  funct3;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } inst_i_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    reg_addr_t  rs2;
    reg_addr_t  rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } inst_s_t;

  typedef struct packed {
    logic [19:0] imm;
    reg_addr_t   rd;
    logic [6:0]  opcode;
  } inst_u_t;

  // one instruction word, four field layouts
  typedef union packed {
    inst_r_t r;
    inst_i_t i;
    inst_s_t s;
    inst_u_t u;
  } inst_u;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_pass_b,
    alu_none
  } alu_op_e;

  typedef struct packed {
    word_t pc;
    word_t inst;
  } if_to_id_t;

  typedef struct packed {
    word_t     pc;
    word_t     inst;
    alu_op_e   alu_op;
    logic      use_imm;
    logic      is_load;
    logic      is_store;
    logic      wen;
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    word_t     imm;
  } id_to_ex_t;

  typedef struct packed {
    word_t     pc;
    word_t     inst;
    logic      is_load;
    logic      is_store;
    logic      wen;
    reg_addr_t rd;
    word_t     result;
    word_t     store_data;
  } ex_to_mem_t;

  typedef struct packed {
    word_t     pc;
    word_t     inst;
    logic      wen;
    reg_addr_t rd;
    word_t     result;
  } mem_to_wb_t;

  // pending is set for a load still waiting on its data
  typedef struct packed {
    logic      valid;
    logic      pending;
    reg_addr_t rd;
    word_t     data;
  } fwd_t;

  typedef struct packed {
    logic  write;
    word_t addr;
    word_t wdata;
  } dmem_req_t;

  typedef struct packed {
    word_t     pc;
    word_t     inst;
    logic      wen;
    reg_addr_t rd;
    word_t     data;
  } commit_t;

endpackage

// ==== if_stage.sv ====
/* instruction fetch stage */

`timescale 1ns/1ps

module if_stage #(
  parameter cpu_pkg::word_t reset_pc = '0
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                id_allowin,
  input  logic                imem_ready,
  input  cpu_pkg::word_t      imem_data,
  output logic                imem_valid,
  output cpu_pkg::word_t      imem_addr,
  output logic                if_to_id_valid,
  output cpu_pkg::if_to_id_t  if_to_id
);
  import cpu_pkg::*;

  word_t     pc;
  logic      fetch_en;
  logic      out_valid;
  if_to_id_t out_q;
  logic      fetch_done;

  // issue only when the output register is free or drains this cycle
  assign imem_valid = fetch_en & (~out_valid | id_allowin);
  assign imem_addr  = pc;
  assign fetch_done = imem_valid & imem_ready;

  assign if_to_id_valid = out_valid;
  assign if_to_id       = out_q;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc        <= reset_pc;
      fetch_en  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      fetch_en <= 1'b1;
      if (fetch_done) begin
        pc        <= pc + 32'd4;
        out_valid <= 1'b1;
      end else if (id_allowin) begin
        out_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fetch_done) begin
      out_q <= '{pc: pc, inst: imem_data};
    end
  end

  // an issued fetch stays up with the same address until accepted
  assert property (@(posedge clock) disable iff (reset)
    imem_valid && !imem_ready |=> imem_valid && $stable(imem_addr));

endmodule

// ==== id_stage.sv ====
/* decode stage */

`timescale 1ns/1ps

module id_stage (
  input  logic                clock,
  input  logic                reset,
  input  logic                if_to_id_valid,
  input  cpu_pkg::if_to_id_t  if_to_id,
  input  logic                ex_allowin,
  output logic                id_allowin,
  output logic                id_to_ex_valid,
  output cpu_pkg::id_to_ex_t  id_to_ex
);
  import cpu_pkg::*;

  logic      id_valid;
  if_to_id_t id_in;
  inst_u     inst;
  alu_op_e   alu_op;
  logic      use_imm;
  logic      is_load;
  logic      is_store;
  logic      wen;
  reg_addr_t rs1;
  reg_addr_t rs2;
  word_t     imm;

  assign id_allowin     = ~id_valid | ex_allowin;
  assign id_to_ex_valid = id_valid;

  always_ff @(posedge clock) begin
    if (reset) begin
      id_valid <= 1'b0;
    end else if (id_allowin) begin
      id_valid <= if_to_id_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (if_to_id_valid && id_allowin) begin
      id_in <= if_to_id;
    end
  end

  assign inst = id_in.inst;

  always_comb begin
    alu_op   = alu_none;
    use_imm  = 1'b0;
    is_load  = 1'b0;
    is_store = 1'b0;
    imm      = '0;
    rs1      = inst.r.rs1;
    rs2      = inst.r.rs2;
    case (inst.r.opcode)
      op_op: begin
        case ({inst.r.funct7, inst.r.funct3})
          {7'b0000000, 3'b000}: alu_op = alu_add;
          {7'b0100000, 3'b000}: alu_op = alu_sub;
          {7'b0000000, 3'b100}: alu_op = alu_xor;
          {7'b0000000, 3'b110}: alu_op = alu_or;
          {7'b0000000, 3'b111}: alu_op = alu_and;
          default:              alu_op = alu_none;
        endcase
      end
      op_op_imm, op_load: begin
        // addi, or lw when funct3 selects a word
        if (inst.i.funct3 == (inst.i.opcode == op_load ? 3'b010 : 3'b000)) begin
          alu_op  = alu_add;
          use_imm = 1'b1;
          is_load = (inst.i.opcode == op_load);
          imm     = {{20{inst.i.imm[11]}}, inst.i.imm};
        end
        rs2 = '0;
      end
      op_store: begin
        if (inst.s.funct3 == 3'b010) begin
          alu_op   = alu_add;
          use_imm  = 1'b1;
          is_store = 1'b1;
          imm      = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
        end
      end
      op_lui: begin
        alu_op  = alu_pass_b;
        use_imm = 1'b1;
        imm     = {inst.u.imm, 12'b0};
        rs1     = '0;
        rs2     = '0;
      end
      default: alu_op = alu_none;
    endcase
    // no sources for unknown encodings, so they never stall
    if (alu_op == alu_none) begin
      rs1 = '0;
      rs2 = '0;
    end
  end

  assign wen = (alu_op != alu_none) && !is_store && (inst.r.rd != '0);

  assign id_to_ex = '{pc: id_in.pc, inst: id_in.inst, alu_op: alu_op,
                      use_imm: use_imm, is_load: is_load, is_store: is_store,
                      wen: wen, rd: inst.r.rd, rs1: rs1, rs2: rs2, imm: imm};

endmodule

// ==== ex_stage.sv ====
/* execute stage */

`timescale 1ns/1ps

module ex_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 id_to_ex_valid,
  input  cpu_pkg::id_to_ex_t   id_to_ex,
  input  logic                 mem_allowin,
  output logic                 ex_allowin,
  input  cpu_pkg::fwd_t        mem_fwd,
  input  cpu_pkg::fwd_t        wb_fwd,
  output cpu_pkg::reg_addr_t   rs1_addr,
  output cpu_pkg::reg_addr_t   rs2_addr,
  input  cpu_pkg::word_t       rs1_data,
  input  cpu_pkg::word_t       rs2_data,
  output logic                 ex_to_mem_valid,
  output cpu_pkg::ex_to_mem_t  ex_to_mem
);
  import cpu_pkg::*;

  logic      ex_valid;
  id_to_ex_t ex_in;
  word_t     src1;
  word_t     src2;
  word_t     op_b;
  word_t     alu_result;
  logic      load_hold;
  logic      ready_go;

  // youngest producer wins, x0 is never forwarded
  function automatic word_t pick_operand(input reg_addr_t addr, input word_t rf_data,
                                         input fwd_t mf, input fwd_t wf);
    if (addr == '0) return '0;
    if (mf.valid && mf.rd == addr) return mf.data;
    if (wf.valid && wf.rd == addr) return wf.data;
    return rf_data;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= id_to_ex_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (id_to_ex_valid && ex_allowin) begin
      ex_in <= id_to_ex;
    end
  end

  assign rs1_addr = ex_in.rs1;
  assign rs2_addr = ex_in.rs2;

  assign src1 = pick_operand(ex_in.rs1, rs1_data, mem_fwd, wb_fwd);
  assign src2 = pick_operand(ex_in.rs2, rs2_data, mem_fwd, wb_fwd);
  assign op_b = ex_in.use_imm ? ex_in.imm : src2;

  // load in memory stage has not returned what we need yet
  assign load_hold = mem_fwd.valid && mem_fwd.pending &&
                     ((ex_in.rs1 != '0 && ex_in.rs1 == mem_fwd.rd) ||
                      (ex_in.rs2 != '0 && ex_in.rs2 == mem_fwd.rd));

  assign ready_go        = ~load_hold;
  assign ex_allowin      = ~ex_valid | (ready_go & mem_allowin);
  assign ex_to_mem_valid = ex_valid & ready_go;

  // loads and stores use alu_add, giving the address
  always_comb begin
    case (ex_in.alu_op)
      alu_add:    alu_result = src1 + op_b;
      alu_sub:    alu_result = src1 - op_b;
      alu_and:    alu_result = src1 & op_b;
      alu_or:     alu_result = src1 | op_b;
      alu_xor:    alu_result = src1 ^ op_b;
      alu_pass_b: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  assign ex_to_mem = '{pc: ex_in.pc, inst: ex_in.inst, is_load: ex_in.is_load,
                       is_store: ex_in.is_store, wen: ex_in.wen, rd: ex_in.rd,
                       result: alu_result, store_data: src2};

endmodule

// ==== mem_stage.sv ====
/* memory access stage */

`timescale 1ns/1ps

module mem_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 ex_to_mem_valid,
  input  cpu_pkg::ex_to_mem_t  ex_to_mem,
  input  logic                 wb_allowin,
  output logic                 mem_allowin,
  output logic                 dmem_valid,
  output cpu_pkg::dmem_req_t   dmem_req,
  input  logic                 dmem_ready,
  input  cpu_pkg::word_t       dmem_rdata,
  output cpu_pkg::fwd_t        mem_fwd,
  output logic                 mem_to_wb_valid,
  output cpu_pkg::mem_to_wb_t  mem_to_wb
);
  import cpu_pkg::*;

  logic       mem_valid;
  ex_to_mem_t mem_in;
  logic       is_mem;
  logic       access_done;
  logic       resp;
  logic       ready_go;
  word_t      rdata_q;
  word_t      final_result;

  assign is_mem = mem_in.is_load | mem_in.is_store;

  // access_done covers a finished access still waiting on writeback
  assign dmem_valid = mem_valid & is_mem & ~access_done;
  assign dmem_req   = '{write: mem_in.is_store, addr: mem_in.result, wdata: mem_in.store_data};
  assign resp       = dmem_valid & dmem_ready;

  assign ready_go        = ~is_mem | access_done | resp;
  assign mem_allowin     = ~mem_valid | (ready_go & wb_allowin);
  assign mem_to_wb_valid = mem_valid & ready_go;

  always_ff @(posedge clock) begin
    if (reset) begin
      mem_valid   <= 1'b0;
      access_done <= 1'b0;
    end else begin
      if (mem_allowin) begin
        mem_valid <= ex_to_mem_valid;
      end
      if (mem_allowin) begin
        access_done <= 1'b0;
      end else if (resp) begin
        access_done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (ex_to_mem_valid && mem_allowin) begin
      mem_in <= ex_to_mem;
    end
    if (resp) begin
      rdata_q <= dmem_rdata;
    end
  end

  always_comb begin
    final_result = mem_in.result;
    if (mem_in.is_load) begin
      final_result = access_done ? rdata_q : dmem_rdata;
    end
  end

  assign mem_fwd = '{valid: mem_valid & mem_in.wen,
                     pending: mem_in.is_load & ~(access_done | resp),
                     rd: mem_in.rd, data: final_result};

  assign mem_to_wb = '{pc: mem_in.pc, inst: mem_in.inst, wen: mem_in.wen,
                       rd: mem_in.rd, result: final_result};

  // a data request holds until the memory takes it
  assert property (@(posedge clock) disable iff (reset)
    dmem_valid && !dmem_ready |=> dmem_valid && $stable(dmem_req));

endmodule

// ==== wb_stage.sv ====
/* writeback and commit */

`timescale 1ns/1ps

module wb_stage (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 mem_to_wb_valid,
  input  cpu_pkg::mem_to_wb_t  mem_to_wb,
  output logic                 wb_allowin,
  output logic                 reg_wen,
  output cpu_pkg::reg_addr_t   reg_waddr,
  output cpu_pkg::word_t       reg_wdata,
  output cpu_pkg::fwd_t        wb_fwd,
  output logic                 commit_valid,
  output cpu_pkg::commit_t     commit
);
  import cpu_pkg::*;

  logic       wb_valid;
  mem_to_wb_t wb_in;

  // retires in one cycle, never back-pressures
  assign wb_allowin = 1'b1;

  always_ff @(posedge clock) begin
    if (reset) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= mem_to_wb_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (mem_to_wb_valid) begin
      wb_in <= mem_to_wb;
    end
  end

  assign reg_wen   = wb_valid & wb_in.wen;
  assign reg_waddr = wb_in.rd;
  assign reg_wdata = wb_in.result;

  assign wb_fwd = '{valid: reg_wen, pending: 1'b0, rd: wb_in.rd, data: wb_in.result};

  assign commit_valid = wb_valid;
  assign commit = '{pc: wb_in.pc, inst: wb_in.inst, wen: wb_in.wen,
                    rd: wb_in.rd, data: wb_in.result};

  // decode clears wen for rd zero
  assert property (@(posedge clock) disable iff (reset) reg_wen |-> reg_waddr != '0);

endmodule

// ==== regfile.sv ====
/* integer register file */

`timescale 1ns/1ps

module regfile (
  input  logic                clock,
  input  logic                reset,
  input  cpu_pkg::reg_addr_t  rs1_addr,
  input  cpu_pkg::reg_addr_t  rs2_addr,
  output cpu_pkg::word_t      rs1_data,
  output cpu_pkg::word_t      rs2_data,
  input  logic                reg_wen,
  input  cpu_pkg::reg_addr_t  reg_waddr,
  input  cpu_pkg::word_t      reg_wdata
);
  import cpu_pkg::*;

  word_t regs [32];

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (reg_wen && reg_waddr != '0) begin
      regs[reg_waddr] <= reg_wdata;
    end
  end

  // x0 reads as zero
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== cpu.sv ====
/* five-stage core top */

`timescale 1ns/1ps

module cpu #(
  parameter cpu_pkg::word_t reset_pc = '0
) (
  input  logic                clock,
  input  logic                reset,
  output logic                imem_valid,
  output cpu_pkg::word_t      imem_addr,
  input  logic                imem_ready,
  input  cpu_pkg::word_t      imem_data,
  output logic                dmem_valid,
  output cpu_pkg::dmem_req_t  dmem_req,
  input  logic                dmem_ready,
  input  cpu_pkg::word_t      dmem_rdata,
  output logic                commit_valid,
  output cpu_pkg::commit_t    commit
);
  import cpu_pkg::*;

  // stage handshakes
  logic if_to_id_valid, id_to_ex_valid, ex_to_mem_valid, mem_to_wb_valid;
  logic id_allowin, ex_allowin, mem_allowin, wb_allowin;

  if_to_id_t  if_to_id;
  id_to_ex_t  id_to_ex;
  ex_to_mem_t ex_to_mem;
  mem_to_wb_t mem_to_wb;
  fwd_t       mem_fwd;
  fwd_t       wb_fwd;

  // register file ports
  reg_addr_t rs1_addr, rs2_addr, reg_waddr;
  word_t     rs1_data, rs2_data, reg_wdata;
  logic      reg_wen;

  if_stage #(.reset_pc(reset_pc)) if_stage_i (
    .clock, .reset, .id_allowin, .imem_ready, .imem_data,
    .imem_valid, .imem_addr, .if_to_id_valid, .if_to_id
  );

  id_stage id_stage_i (
    .clock, .reset, .if_to_id_valid, .if_to_id, .ex_allowin,
    .id_allowin, .id_to_ex_valid, .id_to_ex
  );

  ex_stage ex_stage_i (
    .clock, .reset, .id_to_ex_valid, .id_to_ex, .mem_allowin, .ex_allowin,
    .mem_fwd, .wb_fwd, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .ex_to_mem_valid, .ex_to_mem
  );

  mem_stage mem_stage_i (
    .clock, .reset, .ex_to_mem_valid, .ex_to_mem, .wb_allowin, .mem_allowin,
    .dmem_valid, .dmem_req, .dmem_ready, .dmem_rdata, .mem_fwd,
    .mem_to_wb_valid, .mem_to_wb
  );

  wb_stage wb_stage_i (
    .clock, .reset, .mem_to_wb_valid, .mem_to_wb, .wb_allowin,
    .reg_wen, .reg_waddr, .reg_wdata, .wb_fwd, .commit_valid, .commit
  );

  regfile regfile_i (
    .clock, .reset, .rs1_addr, .rs2_addr, .rs1_data, .rs2_data,
    .reg_wen, .reg_waddr, .reg_wdata
  );

endmodule

// ==== cpu_checker.sv ====
/* commit and store checker */

`timescale 1ns/1ps

module cpu_checker #(
  parameter cpu_pkg::word_t reset_pc = '0
) (
  input  logic                clock,
  input  logic                reset,
  input  logic                imem_valid,
  input  cpu_pkg::word_t      imem_addr,
  input  logic                dmem_valid,
  input  cpu_pkg::dmem_req_t  dmem_req,
  input  logic                dmem_ready,
  input  logic                commit_valid,
  input  cpu_pkg::commit_t    commit,
  output logic                done,
  output int                  value_errors,
  output int                  other_errors,
  output int                  commits_seen
);
  import cpu_pkg::*;

  typedef struct packed {
    logic [127:0] name;
    word_t        pc;
    word_t        inst;
    logic         wen;
    reg_addr_t    rd;
    word_t        data;
  } exp_commit_t;

  typedef struct packed {
    logic [127:0] name;
    word_t        addr;
    word_t        data;
  } exp_store_t;

  exp_commit_t commits [64];
  exp_store_t  stores [16];
  int          n_commits = 0;
  int          n_stores = 0;
  int          commit_idx = 0;
  int          store_idx = 0;
  int          value_count = 0;
  int          other_count = 0;
  logic        reset_q = 1'b0;
  logic        fetch_seen = 1'b0;
  logic        finished = 1'b0;
  exp_commit_t ec;
  exp_store_t  es;

  assign done         = finished;
  assign value_errors = value_count;
  assign other_errors = other_count;
  assign commits_seen = commit_idx;

  task automatic add_commit(input logic [127:0] name, input word_t pc, input word_t inst,
                            input logic wen, input reg_addr_t rd, input word_t data);
    commits[n_commits] = '{name: name, pc: pc, inst: inst, wen: wen, rd: rd, data: data};
    n_commits++;
  endtask

  task automatic add_store(input logic [127:0] name, input word_t addr, input word_t data);
    stores[n_stores] = '{name: name, addr: addr, data: data};
    n_stores++;
  endtask

  task automatic report_mismatch(input logic [127:0] name, input string field,
                                 input word_t expected, input word_t actual);
    value_count++;
    $display("FAIL %0s %0s expected %h actual %h", name, field, expected, actual);
  endtask

  always @(posedge clock) begin
    reset_q <= reset;
    // registers are settled from the second reset edge on
    if (reset_q && (imem_valid !== 1'b0 || dmem_valid !== 1'b0 || commit_valid !== 1'b0)) begin
      other_count++;
      $display("a valid output was high during reset or in the cycle after it");
    end
    if (!reset) begin
      if (imem_valid && !fetch_seen) begin
        fetch_seen <= 1'b1;
        if (imem_addr !== reset_pc) begin
          report_mismatch(128'("first_fetch"), "addr", reset_pc, imem_addr);
        end
      end
      if (dmem_valid && dmem_ready && dmem_req.write) begin
        if (store_idx >= n_stores) begin
          other_count++;
          $display("unexpected store of %h to %h", dmem_req.wdata, dmem_req.addr);
        end else begin
          es = stores[store_idx];
          if (dmem_req.addr !== es.addr) begin
            report_mismatch(es.name, "addr", es.addr, dmem_req.addr);
          end
          if (dmem_req.wdata !== es.data) begin
            report_mismatch(es.name, "data", es.data, dmem_req.wdata);
          end
          store_idx++;
        end
      end
      if (commit_valid) begin
        if (commit_idx >= n_commits) begin
          other_count++;
          $display("extra commit at pc %h", commit.pc);
        end else begin
          ec = commits[commit_idx];
          if (commit.pc !== ec.pc) begin
            report_mismatch(ec.name, "pc", ec.pc, commit.pc);
          end
          if (commit.inst !== ec.inst) begin
            report_mismatch(ec.name, "inst", ec.inst, commit.inst);
          end
          if (commit.wen !== ec.wen) begin
            report_mismatch(ec.name, "wen", 32'(ec.wen), 32'(commit.wen));
          end
          // rd and data only mean something for a register write
          if (ec.wen && commit.rd !== ec.rd) begin
            report_mismatch(ec.name, "rd", 32'(ec.rd), 32'(commit.rd));
          end
          if (ec.wen && commit.data !== ec.data) begin
            report_mismatch(ec.name, "data", ec.data, commit.data);
          end
          commit_idx++;
          if (commit_idx == n_commits) begin
            if (store_idx < n_stores) begin
              other_count++;
              $display("missing stores, %0d of %0d seen", store_idx, n_stores);
            end
            finished <= 1'b1;
          end
        end
      end
    end
  end

endmodule

// ==== tb_cpu.sv ====
/* core testbench */

`timescale 1ns/1ps

module tb_cpu;
  import cpu_pkg::*;

  localparam word_t reset_pc  = 32'h0;
  localparam int    mem_words = 256;

  logic      clock = 1'b0;
  logic      reset = 1'b1;
  logic      imem_valid;
  word_t     imem_addr;
  logic      imem_ready = 1'b0;
  word_t     imem_data = '0;
  logic      dmem_valid;
  dmem_req_t dmem_req;
  logic      dmem_ready = 1'b0;
  word_t     dmem_rdata = '0;
  logic      commit_valid;
  commit_t   commit;

  logic      done;
  int        value_errors;
  int        other_errors;
  int        commits_seen;
  int        n_expected = 0;
  logic      tests_ok;

  word_t imem [mem_words];
  word_t dmem_init [mem_words];
  word_t dmem [mem_words];

  logic [31:0] lfsr;
  logic        i_busy;
  logic [2:0]  i_wait;
  logic        d_busy;
  logic [2:0]  d_wait;
  logic [2:0]  draw;

  always #5 clock = ~clock;

  cpu #(.reset_pc(reset_pc)) cpu_i (
    .clock, .reset, .imem_valid, .imem_addr, .imem_ready, .imem_data,
    .dmem_valid, .dmem_req, .dmem_ready, .dmem_rdata, .commit_valid, .commit
  );

  cpu_checker #(.reset_pc(reset_pc)) checker_i (
    .clock, .reset, .imem_valid, .imem_addr, .dmem_valid, .dmem_req, .dmem_ready,
    .commit_valid, .commit, .done, .value_errors, .other_errors, .commits_seen
  );

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_wait(output logic [2:0] n);
    for (int b = 0; b < 3; b++) begin
      lfsr = lfsr_step(lfsr);
      n[b] = lfsr[0];
    end
  endtask

  task automatic load_tests(output logic ok);
    int           fd;
    int           code;
    logic [7:0]   kind;
    logic [127:0] name;
    word_t        addr;
    word_t        value;
    logic         wen;
    reg_addr_t    rd;
    logic [767:0] rest;
    for (int i = 0; i < mem_words; i++) begin
      // addi x0, x0, addr beyond the program
      imem[i]      = {12'(i * 4), 20'h00013};
      dmem_init[i] = 32'hd0d0_0000 | 32'(i * 4);
    end
    fd = $fopen("cpu_tests.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while ($fscanf(fd, "%s", kind) == 1) begin
        if (kind == "I") begin
          code = $fscanf(fd, "%h %h", addr, value);
          ok = ok && (code == 2);
          imem[addr[9:2]] = value;
        end else if (kind == "D") begin
          code = $fscanf(fd, "%h %h", addr, value);
          ok = ok && (code == 2);
          dmem_init[addr[9:2]] = value;
        end else if (kind == "C") begin
          code = $fscanf(fd, "%s %h %h %d %h", name, addr, wen, rd, value);
          ok = ok && (code == 5);
          // the program lines come first, so the expected word is known
          checker_i.add_commit(name, addr, imem[addr[9:2]], wen, rd, value);
          n_expected++;
        end else if (kind == "S") begin
          code = $fscanf(fd, "%s %h %h", name, addr, value);
          ok = ok && (code == 3);
          checker_i.add_store(name, addr, value);
        end else begin
          code = $fgets(rest, fd);
        end
      end
      $fclose(fd);
    end
  endtask

  // both memory models, one lfsr, fetch port drawn first
  always @(posedge clock) begin
    if (reset) begin
      lfsr = 32'h0f70_2c5f;
      imem_ready <= 1'b0;
      i_busy     <= 1'b0;
      dmem_ready <= 1'b0;
      d_busy     <= 1'b0;
      for (int i = 0; i < mem_words; i++) begin
        dmem[i] <= dmem_init[i];
      end
    end else begin
      // ready lasts one cycle, taken or withdrawn
      if (imem_ready) begin
        imem_ready <= 1'b0;
        i_busy     <= 1'b0;
      end else if (i_busy) begin
        if (i_wait == 3'd0) begin
          imem_ready <= 1'b1;
          imem_data  <= imem[imem_addr[9:2]];
        end else begin
          i_wait <= i_wait - 3'd1;
        end
      end else if (imem_valid) begin
        draw_wait(draw);
        i_busy <= 1'b1;
        i_wait <= draw;
      end
      if (dmem_ready) begin
        dmem_ready <= 1'b0;
        d_busy     <= 1'b0;
        if (dmem_valid && dmem_req.write) begin
          dmem[dmem_req.addr[9:2]] <= dmem_req.wdata;
        end
      end else if (d_busy) begin
        if (d_wait == 3'd0) begin
          dmem_ready <= 1'b1;
          dmem_rdata <= dmem[dmem_req.addr[9:2]];
        end else begin
          d_wait <= d_wait - 3'd1;
        end
      end else if (dmem_valid) begin
        draw_wait(draw);
        d_busy <= 1'b1;
        d_wait <= draw;
      end
    end
  end

  initial begin
    load_tests(tests_ok);
    if (!tests_ok) begin
      $display("cannot open or parse cpu_tests.txt");
      $display("RESULT: FAIL");
      $finish;
    end else begin
      repeat (4) @(posedge clock);
      reset <= 1'b0;
      wait (done);
      $display("checks done: %0d wrong values, %0d other errors", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
        $display("RESULT: PASS");
      end else begin
        $display("RESULT: FAIL");
      end
      $finish;
    end
  end

  // watchdog sized from the number of expected commits
  initial begin
    wait (!reset);
    repeat (200 + 30 * n_expected) @(negedge clock);
    $display("timeout: %0d of %0d commits seen", commits_seen, n_expected);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// ==== cpu_tests.txt ====
# I addr word | D addr word | C name pc wen rd data | S name addr data
# all numbers hex except rd, which is decimal
I 00 00500093
I 04 00108133
I 08 001141b3
I 0c 12345237
I 10 003262b3
I 14 0022f333
I 18 405303b3
I 1c 04002403
I 20 ff340493
I 24 08902023
I 28 06300013
I 2c 08002503
I 30 000505b3
D 40 cafef00d
C addi_x1 00 1 1 00000005
C add_fwd 04 1 2 0000000a
C xor_fwd 08 1 3 0000000f
C lui_x4 0c 1 4 12345000
C or_x5 10 1 5 1234500f
C and_x6 14 1 6 0000000a
C sub_x7 18 1 7 edcbaffb
C lw_init 1c 1 8 cafef00d
C load_use 20 1 9 cafef000
C sw_commit 24 0 0 00000000
C addi_x0 28 0 0 00000000
C lw_back 2c 1 10 cafef000
C x0_read 30 1 11 cafef000
S sw_store 80 cafef000

// ==== sources.f ====
cpu_pkg.sv
if_stage.sv
id_stage.sv
ex_stage.sv
mem_stage.sv
wb_stage.sv
regfile.sv
cpu.sv
cpu_checker.sv
tb_cpu.sv

// ==== Makefile ====
# Verilator build and run of the core testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --assert --top-module tb_cpu -f sources.f --Mdir obj_dir -o vtb_cpu
	./obj_dir/vtb_cpu | tee sim.log
	grep -q "^RESULT: PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log
